/* verilog/tlu_macros.svh */
// TLU controller widths and default settings
// shared by the package and the RTL blocks
`ifndef TLU_MACROS_SVH
`define TLU_MACROS_SVH

// output word layout
`define TLU_WORD_W 32
`define TLU_TRIG_NUM_W 15
`define TLU_WORD_MARKER_BIT 31

// serial trigger number link
// a bit count of 0 selects the longest length
`define TLU_MAX_BITS 32

// CLK cycles per TLU bit period
`define TLU_DIVISOR_DEFAULT 12

`endif

/* verilog/tlu_pkg.sv */
// TLU controller types
// configuration and error structs, FSM states
`default_nettype none

`include "tlu_macros.svh"

package tlu_pkg;

    typedef logic [1:0] tlu_mode_t;
    typedef logic [4:0] bit_count_t;
    typedef logic [7:0] timeout_t;
    typedef logic [`TLU_TRIG_NUM_W-1:0] trig_num_t;
    typedef logic [`TLU_WORD_W-1:0] tlu_word_t;

    typedef struct packed {
        tlu_mode_t  mode;
        timeout_t   trigger_low_timeout;
        bit_count_t clock_cycles;
        logic       msb_first;
        logic       disable_veto;
    } tlu_cfg_t;

    typedef struct packed {
        logic accept_error;
        logic low_timeout_error;
    } tlu_err_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_TRIGGER_LOW,
        SEND_TLU_CLOCK,
        LATCH_DATA,
        WAIT_DATA_SAVED
    } tlu_state_t;

    // number of serial bits where 0 stands for the full length
    function automatic logic [5:0] bit_len(input bit_count_t clock_cycles);
        return (clock_cycles == '0) ? 6'(`TLU_MAX_BITS) : {1'b0, clock_cycles};
    endfunction

endpackage

`default_nettype wire

/* verilog/tlu_handshake_fsm.sv */
// TLU trigger handshake FSM
// accepts triggers, waits for trigger low, runs the TLU clock
// and drives busy, veto and the error flags
`timescale 1ns/1ps
`default_nettype none

`include "tlu_macros.svh"

module tlu_handshake_fsm
#(
    parameter int DIVISOR = `TLU_DIVISOR_DEFAULT
) (
    input  wire                     CLK,
    input  wire                     RESET,
    input  wire tlu_pkg::tlu_cfg_t  cfg,
    input  wire                     cmd_ready,
    input  wire                     ext_start_enable,
    input  wire                     trigger_flag,
    input  wire                     ext_veto,
    input  wire                     fifo_near_full,
    input  wire                     tlu_trigger,
    input  wire                     fifo_empty,
    output logic                    busy,
    output logic                    clock_enable,
    output logic                    assert_veto,
    output logic                    ext_start_flag,
    output logic                    latch,
    output tlu_pkg::tlu_err_t       errors
);
    import tlu_pkg::*;

    localparam int CNT_W = $clog2(`TLU_MAX_BITS * DIVISOR);

    tlu_state_t         state;
    tlu_state_t         next;
    timeout_t           timeout_cnt;
    logic [CNT_W-1:0]   clk_cnt;
    logic [CNT_W-1:0]   clk_last;
    logic               trigger_seen;
    logic               veto_cond;
    logic               veto_state;

    // TLU clock runs N bit periods
    assign clk_last = CNT_W'(bit_len(cfg.clock_cycles) * DIVISOR - 1);

    // trigger line only counts in the handshake modes
    assign trigger_seen = trigger_flag || (tlu_trigger && cfg.mode[1]);

    assign veto_cond = !ext_start_enable || (fifo_near_full && !cfg.disable_veto);
    assign veto_state = (next == IDLE) || (next == LATCH_DATA) || (next == WAIT_DATA_SAVED);

    always_comb
    begin
        next = state;
        case (state)
            IDLE:
            begin
                if (cmd_ready && ext_start_enable && !ext_veto && trigger_seen)
                    next = cfg.mode[1] ? WAIT_TRIGGER_LOW : WAIT_DATA_SAVED;
            end
            WAIT_TRIGGER_LOW:
            begin
                if (!tlu_trigger || errors.low_timeout_error)
                    next = (cfg.mode == 2'd3) ? SEND_TLU_CLOCK : WAIT_DATA_SAVED;
            end
            SEND_TLU_CLOCK:
            begin
                if (clk_cnt == clk_last)
                    next = LATCH_DATA;
            end
            LATCH_DATA:
            begin
                next = WAIT_DATA_SAVED;
            end
            WAIT_DATA_SAVED:
            begin
                // word read and system ready again
                if (fifo_empty && cmd_ready)
                    next = IDLE;
            end
            default:
            begin
                next = IDLE;
            end
        endcase
    end

    // outputs registered from the next state
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= IDLE;
            busy <= 1'b0;
            clock_enable <= 1'b0;
            assert_veto <= 1'b0;
            ext_start_flag <= 1'b0;
            latch <= 1'b0;
            timeout_cnt <= '0;
            clk_cnt <= '0;
            errors <= '0;
        end
        else
        begin
            state <= next;
            busy <= (next != IDLE);
            clock_enable <= (next == SEND_TLU_CLOCK);
            latch <= (next == LATCH_DATA);
            ext_start_flag <= (state == IDLE) && (next != IDLE);
            assert_veto <= veto_cond && veto_state;

            if (state == WAIT_TRIGGER_LOW)
                timeout_cnt <= timeout_cnt + 1'b1;
            else
                timeout_cnt <= '0;

            if (state == SEND_TLU_CLOCK)
                clk_cnt <= clk_cnt + 1'b1;
            else
                clk_cnt <= '0;

            // timeout flag lives for one transaction
            if (state == IDLE)
                errors.low_timeout_error <= 1'b0;
            else if ((state == WAIT_TRIGGER_LOW) && (cfg.trigger_low_timeout != '0)
                     && (timeout_cnt >= cfg.trigger_low_timeout))
                errors.low_timeout_error <= 1'b1;

            // refused trigger kept until the next idle cycle
            if ((state == IDLE) && (next == IDLE))
                errors.accept_error <= tlu_trigger && ext_start_enable;
        end
    end

    // TLU clock only inside a busy transaction
    a_clock_in_busy: assert property (@(posedge CLK) disable iff (RESET)
        clock_enable |-> busy);

    a_start_single: assert property (@(posedge CLK) disable iff (RESET)
        ext_start_flag |=> !ext_start_flag);

endmodule

`default_nettype wire

/* verilog/tlu_serial_capture.sv */
// TLU serial trigger number capture
// one sample per bit period, result in either bit order
`timescale 1ns/1ps
`default_nettype none

`include "tlu_macros.svh"

module tlu_serial_capture
#(
    parameter int DIVISOR = `TLU_DIVISOR_DEFAULT
) (
    input  wire                     CLK,
    input  wire                     RESET,
    input  wire tlu_pkg::tlu_cfg_t  cfg,
    input  wire                     clock_enable,
    input  wire                     tlu_trigger,
    output tlu_pkg::trig_num_t      trig_num
);
    import tlu_pkg::*;

    localparam int DIV_W = $clog2(DIVISOR);

    logic [DIV_W-1:0]           div_cnt;
    logic [5:0]                 bit_idx;
    logic                       sample;
    logic [`TLU_MAX_BITS-1:0]   shift_data;
    logic [`TLU_MAX_BITS-1:0]   reversed;
    logic [`TLU_MAX_BITS-1:0]   result;

    // last cycle of each bit window
    assign sample = clock_enable && (div_cnt == DIV_W'(DIVISOR - 1));

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            div_cnt <= '0;
            bit_idx <= '0;
        end
        else if (!clock_enable)
        begin
            div_cnt <= '0;
            bit_idx <= '0;
        end
        else if (sample)
        begin
            div_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // first bit ends up at position N-1 and older contents are dropped
    always_ff @(posedge CLK)
    begin
        if (sample)
        begin
            if (bit_idx == '0)
                shift_data <= {{(`TLU_MAX_BITS-1){1'b0}}, tlu_trigger};
            else
                shift_data <= {shift_data[`TLU_MAX_BITS-2:0], tlu_trigger};
        end
    end

    always_comb
    begin
        for (int i = 0; i < `TLU_MAX_BITS; i++)
            reversed[i] = shift_data[`TLU_MAX_BITS-1-i];
    end

    // first received bit to bit 0 unless msb first
    assign result = cfg.msb_first ? shift_data
        : (reversed >> (6'(`TLU_MAX_BITS) - bit_len(cfg.clock_cycles)));

    assign trig_num = result[`TLU_TRIG_NUM_W-1:0];

    a_max_samples: assert property (@(posedge CLK) disable iff (RESET)
        sample |-> (bit_idx < 6'(`TLU_MAX_BITS)));

endmodule

`default_nettype wire

/* verilog/tlu_word_buffer.sv */
// TLU output word buffer
// holds one formatted word until it is read
`timescale 1ns/1ps
`default_nettype none

`include "tlu_macros.svh"

module tlu_word_buffer
(
    input  wire                     CLK,
    input  wire                     RESET,
    input  wire                     latch,
    input  wire tlu_pkg::trig_num_t trig_num,
    input  wire tlu_pkg::tlu_err_t  errors,
    input  wire                     fifo_read,
    output logic                    fifo_empty,
    output tlu_pkg::tlu_word_t      fifo_data
);
    import tlu_pkg::*;

    tlu_word_t next_word;

    // marker, error flags, zero gap, trigger number
    always_comb
    begin
        next_word = '0;
        next_word[`TLU_WORD_MARKER_BIT] = 1'b1;
        next_word[`TLU_WORD_MARKER_BIT-1] = errors.accept_error;
        next_word[`TLU_WORD_MARKER_BIT-2] = errors.low_timeout_error;
        next_word[`TLU_TRIG_NUM_W-1:0] = trig_num;
    end

    always_ff @(posedge CLK)
    begin
        if (latch)
            fifo_data <= next_word;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            fifo_empty <= 1'b1;
        else if (latch)
            fifo_empty <= 1'b0;
        else if (fifo_read)
            fifo_empty <= 1'b1;
    end

    // FSM waits for the read before the next word
    a_no_overwrite: assert property (@(posedge CLK) disable iff (RESET)
        latch |-> fifo_empty);

endmodule

`default_nettype wire

/* verilog/tlu_ctrl_top.sv */
// TLU controller top level
// handshake FSM, serial capture and output word buffer
`timescale 1ns/1ps
`default_nettype none

`include "tlu_macros.svh"

module tlu_ctrl_top
#(
    parameter int DIVISOR = `TLU_DIVISOR_DEFAULT
) (
    input  wire                     CLK,
    input  wire                     RESET,
    input  wire tlu_pkg::tlu_cfg_t  cfg,
    input  wire                     cmd_ready,
    input  wire                     ext_start_enable,
    input  wire                     trigger_flag,
    input  wire                     ext_veto,
    input  wire                     fifo_near_full,
    input  wire                     fifo_read,
    input  wire                     tlu_trigger,
    output logic                    busy,
    output logic                    clock_enable,
    output logic                    assert_veto,
    output logic                    ext_start_flag,
    output logic                    fifo_empty,
    output tlu_pkg::tlu_word_t      fifo_data
);
    import tlu_pkg::*;

    tlu_err_t   errors;
    trig_num_t  trig_num;
    logic       latch;

    tlu_handshake_fsm #(
        .DIVISOR(DIVISOR)
    ) u_fsm (
        .CLK(CLK),
        .RESET(RESET),
        .cfg(cfg),
        .cmd_ready(cmd_ready),
        .ext_start_enable(ext_start_enable),
        .trigger_flag(trigger_flag),
        .ext_veto(ext_veto),
        .fifo_near_full(fifo_near_full),
        .tlu_trigger(tlu_trigger),
        .fifo_empty(fifo_empty),
        .busy(busy),
        .clock_enable(clock_enable),
        .assert_veto(assert_veto),
        .ext_start_flag(ext_start_flag),
        .latch(latch),
        .errors(errors)
    );

    // trigger line doubles as the serial data line
    tlu_serial_capture #(
        .DIVISOR(DIVISOR)
    ) u_capture (
        .CLK(CLK),
        .RESET(RESET),
        .cfg(cfg),
        .clock_enable(clock_enable),
        .tlu_trigger(tlu_trigger),
        .trig_num(trig_num)
    );

    tlu_word_buffer u_buffer (
        .CLK(CLK),
        .RESET(RESET),
        .latch(latch),
        .trig_num(trig_num),
        .errors(errors),
        .fifo_read(fifo_read),
        .fifo_empty(fifo_empty),
        .fifo_data(fifo_data)
    );

endmodule

`default_nettype wire

/* test/tb_tlu_ctrl.sv */
// TLU controller testbench
// trace driven TLU model with word, timing, veto and error checks
`timescale 1ns/1ps
`default_nettype none

`include "tlu_macros.svh"

module tb_tlu_ctrl;
    import tlu_pkg::*;

    localparam int DIV = `TLU_DIVISOR_DEFAULT;

    logic       CLK;
    logic       RESET;
    tlu_cfg_t   cfg;
    logic       cmd_ready;
    logic       ext_start_enable;
    logic       trigger_flag;
    logic       ext_veto;
    logic       fifo_near_full;
    logic       fifo_read;
    logic       tlu_trigger;
    logic       busy;
    logic       clock_enable;
    logic       assert_veto;
    logic       ext_start_flag;
    logic       fifo_empty;
    tlu_word_t  fifo_data;

    // TLU model and monitor state
    logic        armed;
    logic [31:0] tlu_num;
    int          n_bits;
    int          hold_left;
    int          ce_cnt;
    int          start_cnt;
    int          busy_cycles;
    logic        word_seen;

    int     err_count;
    int     test_count;
    int     test_fails;
    integer seed;

    tlu_ctrl_top #(
        .DIVISOR(DIV)
    ) DUT (
        .CLK(CLK),
        .RESET(RESET),
        .cfg(cfg),
        .cmd_ready(cmd_ready),
        .ext_start_enable(ext_start_enable),
        .trigger_flag(trigger_flag),
        .ext_veto(ext_veto),
        .fifo_near_full(fifo_near_full),
        .fifo_read(fifo_read),
        .tlu_trigger(tlu_trigger),
        .busy(busy),
        .clock_enable(clock_enable),
        .assert_veto(assert_veto),
        .ext_start_flag(ext_start_flag),
        .fifo_empty(fifo_empty),
        .fifo_data(fifo_data)
    );

    always #10 CLK = ~CLK;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("ERROR %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1)
        else
        begin
            $display("at %0t ns: %s", $time, what);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before)
            $display("%s: ok", name);
        else
        begin
            $display("%s: failed with %0d errors", name, err_count - errs_before);
            test_fails++;
        end
    endtask

    // TLU model holds the line and then shifts its number out during clock_enable
    always @(negedge CLK)
    begin : tlu_model
        int bit_pos;
        if (armed)
        begin
            if (ext_start_flag)
                start_cnt++;
            if (busy)
                busy_cycles++;
            if (!fifo_empty)
                word_seen = 1'b1;
            if (clock_enable)
            begin
                if ((hold_left > 0) && (cfg.trigger_low_timeout == '0))
                    check_true(1'b0, "TLU clock started while the trigger was still high");
                hold_left = 0;
                bit_pos = ce_cnt / DIV;
                if (bit_pos < n_bits)
                    tlu_trigger = cfg.msb_first ? tlu_num[n_bits-1-bit_pos] : tlu_num[bit_pos];
                ce_cnt++;
            end
            else if (busy)
            begin
                if (hold_left > 0)
                    hold_left--;
                else
                    tlu_trigger = 1'b0;
            end
        end
    end

    task automatic drive_veto(input logic ese, input logic near_full, input logic dis,
                              input logic exp_veto);
        @(negedge CLK);
        ext_start_enable = ese;
        fifo_near_full = near_full;
        cfg.disable_veto = dis;
        @(negedge CLK);
        check_value("assert_veto", assert_veto, exp_veto);
    endtask

    task automatic run_veto_test();
        int errs_before;
        errs_before = err_count;
        drive_veto(1'b0, 1'b0, 1'b0, 1'b1);
        drive_veto(1'b1, 1'b1, 1'b0, 1'b1);
        drive_veto(1'b1, 1'b1, 1'b1, 1'b0);
        drive_veto(1'b1, 1'b0, 1'b0, 1'b0);
        // external veto blocks any trigger
        @(negedge CLK);
        cfg.mode = 2'd3;
        ext_veto = 1'b1;
        trigger_flag = 1'b1;
        tlu_trigger = 1'b1;
        repeat (6)
        begin
            @(negedge CLK);
            check_value("busy", busy, 0);
            check_value("ext_start_flag", ext_start_flag, 0);
        end
        ext_veto = 1'b0;
        trigger_flag = 1'b0;
        tlu_trigger = 1'b0;
        repeat (3) @(negedge CLK);
        report_test("veto and external veto", errs_before);
    endtask

    task automatic run_test(input int mode, input int bits, input int msb, input int timeout,
                            input logic [31:0] num, input int hold, input int delay,
                            input int refuse, input int exp_acc, input int exp_to);
        int          errs_before;
        int          n;
        int          wait_cnt;
        int          extra;
        logic [31:0] mask;
        tlu_word_t   exp_word;
        errs_before = err_count;
        n = (bits == 0) ? `TLU_MAX_BITS : bits;
        mask = (n == 32) ? 32'hffff_ffff : ((32'd1 << n) - 1);
        exp_word = '0;
        exp_word[`TLU_WORD_MARKER_BIT] = 1'b1;
        exp_word[30] = exp_acc[0];
        exp_word[29] = exp_to[0];
        exp_word[`TLU_TRIG_NUM_W-1:0] = (num & mask) & 32'h7fff;

        @(negedge CLK);
        cfg.mode = mode[1:0];
        cfg.clock_cycles = bits[4:0];
        cfg.msb_first = msb[0];
        cfg.trigger_low_timeout = timeout[7:0];
        cfg.disable_veto = 1'b0;
        tlu_num = num;
        n_bits = n;
        hold_left = hold;
        ce_cnt = 0;
        start_cnt = 0;
        busy_cycles = 0;
        word_seen = 1'b0;
        cmd_ready = (refuse == 0);
        trigger_flag = 1'b1;
        tlu_trigger = 1'b1;
        armed = 1'b1;

        // trigger arrives while the system is not ready
        if (refuse != 0)
        begin
            repeat (3)
            begin
                @(negedge CLK);
                check_value("busy", busy, 0);
            end
            cmd_ready = 1'b1;
        end

        wait_cnt = 0;
        while (!busy && (wait_cnt < 20))
        begin
            @(negedge CLK);
            wait_cnt++;
        end
        check_true(busy, "timed out waiting for busy to rise");
        trigger_flag = 1'b0;

        if (mode == 3)
        begin
            wait_cnt = 0;
            while (fifo_empty && (wait_cnt < 2000))
            begin
                @(negedge CLK);
                wait_cnt++;
            end
            check_true(!fifo_empty, "timed out waiting for the data word");
            check_value("fifo_data", fifo_data, exp_word);
            check_value("clock_enable cycles", ce_cnt, n * DIV);
            extra = delay + ($random(seed) & 3);
            repeat (extra)
            begin
                @(negedge CLK);
                check_value("fifo_data", fifo_data, exp_word);
                check_value("busy", busy, 1);
            end
            fifo_read = 1'b1;
            @(negedge CLK);
            fifo_read = 1'b0;
            check_value("fifo_empty", fifo_empty, 1);
        end

        wait_cnt = 0;
        while (busy && (wait_cnt < 200))
        begin
            @(negedge CLK);
            wait_cnt++;
        end
        check_true(!busy, "timed out waiting for busy to fall");
        check_value("ext_start_flag pulses", start_cnt, 1);
        if (mode != 3)
        begin
            check_true(!word_seen, "a data word appeared outside mode 3");
            check_value("clock_enable cycles", ce_cnt, 0);
            check_true(busy_cycles > hold, "busy fell while the trigger was held high");
        end
        armed = 1'b0;
        tlu_trigger = 1'b0;
        trigger_flag = 1'b0;
        repeat (3) @(negedge CLK);
        report_test($sformatf("test %0d mode %0d bits %0d msb %0d timeout %0d",
                              test_count, mode, bits, msb, timeout), errs_before);
    endtask

    initial
    begin
        integer            fd;
        integer            cnt;
        integer            fields;
        logic [8*160-1:0]  line;
        integer            t_mode, t_bits, t_msb, t_timeout, t_hold;
        integer            t_delay, t_refuse, t_acc, t_to;
        logic [31:0]       t_num;
        int                errs_before;

        CLK = 1'b0;
        RESET = 1'b1;
        cfg = '0;
        cmd_ready = 1'b1;
        ext_start_enable = 1'b1;
        trigger_flag = 1'b0;
        ext_veto = 1'b0;
        fifo_near_full = 1'b0;
        fifo_read = 1'b0;
        tlu_trigger = 1'b0;
        armed = 1'b0;
        tlu_num = '0;
        n_bits = 0;
        hold_left = 0;
        ce_cnt = 0;
        start_cnt = 0;
        busy_cycles = 0;
        word_seen = 1'b0;
        err_count = 0;
        test_count = 0;
        test_fails = 0;
        seed = 80;

        repeat (5) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        errs_before = err_count;
        check_value("busy", busy, 0);
        check_value("clock_enable", clock_enable, 0);
        check_value("ext_start_flag", ext_start_flag, 0);
        check_value("fifo_empty", fifo_empty, 1);
        check_value("assert_veto", assert_veto, 0);
        report_test("reset", errs_before);

        run_veto_test();

        fd = $fopen("test/tlu_trace.txt", "r");
        if (fd == 0)
            check_true(1'b0, "could not open test/tlu_trace.txt");
        else
        begin
            while (!$feof(fd))
            begin
                line = '0;
                cnt = $fgets(line, fd);
                fields = $sscanf(line, "%d %d %d %d %h %d %d %d %d %d", t_mode, t_bits,
                                 t_msb, t_timeout, t_num, t_hold, t_delay, t_refuse,
                                 t_acc, t_to);
                // comment and blank lines do not scan
                if ((cnt > 0) && (fields == 10))
                    run_test(t_mode, t_bits, t_msb, t_timeout, t_num, t_hold, t_delay,
                             t_refuse, t_acc, t_to);
            end
            $fclose(fd);
        end

        $display("%0d tests, %0d failed, %0d check errors", test_count, test_fails, err_count);
        if ((err_count == 0) && (test_count > 2))
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+verilog
verilog/tlu_pkg.sv
verilog/tlu_handshake_fsm.sv
verilog/tlu_serial_capture.sv
verilog/tlu_word_buffer.sv
verilog/tlu_ctrl_top.sv
test/tb_tlu_ctrl.sv

/* test/tlu_trace.txt */
# mode bits msb timeout tlu_number(hex) hold read_delay refuse exp_accept_err exp_timeout_err
# bits 0 means 32, hold is the number of cycles the trigger stays high after busy
3 15 0 0  00005a3c 0  2  0 0 0
3 15 1 0  00001234 0  0  0 0 0
3 16 0 10 0000c3a5 0  3  0 0 0
3 16 1 10 0000beef 0  1  0 0 0
3 0  0 0  9e3779b9 0  4  0 0 0
3 0  1 0  12345678 0  0  0 0 0
0 8  0 0  00000000 0  0  0 0 0
1 8  0 0  00000000 0  0  0 0 0
2 8  0 0  00000000 0  0  0 0 0
2 8  0 0  00000000 30 0  0 0 0
3 15 0 20 00002aaa 60 2  0 0 1
3 15 0 0  00001111 40 2  0 0 0
3 16 1 0  00007777 0  12 1 1 0
3 4  1 5  0000000b 0  20 0 0 0
3 1  0 0  00000001 0  1  0 0 0
